// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := pov_driver_tb
FILE_LIST := pov_driver_top.f
BUILD_DIR := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
LOG       := sim.log
FAIL_MSG  := Simulation FAILED
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended without a result"; exit 1; fi
	@echo "Run passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/pov_driver_assertions.sv ====
`default_nettype none

module pov_driver_assertions (
    input wire                             clock_33,
    input wire                             nrst,
    input wire                             driver_sclk,
    input wire                             driver_lat,
    input wire                             driver_gclk,
    input wire pov_driver_pkg::lane_word_t pattern_word,
    input wire                             pattern_valid,
    input wire                             pattern_ready,
    input wire                             new_config
);

    import pov_driver_pkg::*;

    int         failure_count = 0;
    logic [3:0] blank_left;

    // Cycles still to go in the window after lat
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            blank_left <= '0;
        end else if (driver_lat) begin
            blank_left <= 4'(BLANKING_CYCLES);
        end else if (blank_left != '0) begin
            blank_left <= blank_left - 4'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Handshake and pulse widths
    //////////////////////////////////////////////////////////////////////

    word_held: assert property (@(posedge clock_33) disable iff (!nrst)
        pattern_valid && !pattern_ready |=> $stable(pattern_word))
        else begin
            $error("pattern_word changed while valid was high and ready low");
            failure_count++;
        end

    lat_single: assert property (@(posedge clock_33) disable iff (!nrst)
        driver_lat |=> !driver_lat)
        else begin
            $error("driver_lat stayed high for more than one cycle");
            failure_count++;
        end

    config_pulse: assert property (@(posedge clock_33) disable iff (!nrst)
        new_config |=> !new_config)
        else begin
            $error("new_config stayed high for more than one cycle");
            failure_count++;
        end

    //////////////////////////////////////////////////////////////////////
    // Blanking window
    //////////////////////////////////////////////////////////////////////

    // Lat cycle itself plus the blanking cycles behind it
    blank_quiet: assert property (@(posedge clock_33) disable iff (!nrst)
        (driver_lat || blank_left != '0) |-> !driver_sclk && !driver_gclk && !pattern_ready)
        else begin
            $error("sclk, gclk or pattern_ready active inside the blanking window");
            failure_count++;
        end

endmodule

bind pov_driver_top pov_driver_assertions pov_driver_assertions_inst (
    .clock_33      (clock_33),
    .nrst          (nrst),
    .driver_sclk   (driver_sclk),
    .driver_lat    (driver_lat),
    .driver_gclk   (driver_gclk),
    .pattern_word  (pattern_word),
    .pattern_valid (pattern_valid),
    .pattern_ready (pattern_ready),
    .new_config    (new_config)
);

`default_nettype wire

// ==== bench/pov_driver_tb.sv ====
`default_nettype none

module pov_driver_tb;

    import pov_driver_pkg::*;

    localparam int SPI_CYCLES    = 8 * CONF_BITS + 16;
    localparam int COLUMN_CYCLES = 2 * WORDS_PER_COLUMN + BLANKING_CYCLES + 6;
    localparam int FRAME_CYCLES  = 2 * CONF_BITS + BLANKING_CYCLES + 6 + COLUMN_CYCLES;
    // Sum of all tests in order plus a margin
    localparam int TIMEOUT_CYCLES = 100 + (SPI_CYCLES + FRAME_CYCLES) + 7 * COLUMN_CYCLES
        + (COLUMN_CYCLES + SPI_CYCLES + FRAME_CYCLES + 4 * COLUMN_CYCLES) + 4 * COLUMN_CYCLES
        + (SPI_CYCLES + 2 * COLUMN_CYCLES) + (SPI_CYCLES + FRAME_CYCLES + 200) + 500;

    logic       clock_33;
    logic       nrst;
    logic       spi_clk;
    logic       spi_ss;
    logic       spi_mosi;
    logic       spi_miso;
    logic       driver_sclk;
    logic       driver_lat;
    logic       driver_gclk;
    lane_word_t driver_sin;

    integer     seed = 32'h68580406;
    int         cycles = 0;
    int         errors = 0;
    int         tests_run = 0;
    int         failures_at_start;
    int         config_frames = 0;
    int         data_columns = 0;
    int         lat_count = 0;
    int         word_index = 0;
    logic       sclk_q = 1'b0;
    string      test_name = "startup";
    conf_word_t sent_config = '0;
    conf_word_t active_config = '0;
    lane_word_t frame_words[$];

    pov_driver_top pov_driver_top_inst (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .spi_clk     (spi_clk),
        .spi_ss      (spi_ss),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .driver_sclk (driver_sclk),
        .driver_lat  (driver_lat),
        .driver_gclk (driver_gclk),
        .driver_sin  (driver_sin)
    );

    initial begin
        clock_33 = 1'b0;
        forever #2 clock_33 = ~clock_33;
    end

    always @(posedge clock_33) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, test %s did not finish", cycles, test_name);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int total_failures();
        return errors + pov_driver_top_inst.pov_driver_assertions_inst.failure_count;
    endfunction

    task automatic report_mismatch(input logic [47:0] expected, input logic [47:0] actual);
        $display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
        errors++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        failures_at_start = total_failures();
    endtask

    task automatic end_test();
        tests_run++;
        if (total_failures() == failures_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d failures", test_name, total_failures() - failures_at_start);
        end
    endtask

    function automatic lane_word_t rotate_left(input lane_word_t word, input int amount);
        return (word << amount) | (word >> (LANES - amount));
    endfunction

    // Words per revolution where a zero count means 256 columns
    function automatic int revolution_words(input conf_word_t word);
        column_count_t columns;
        columns = word[COLUMNS_MSB:COLUMNS_LSB];
        return WORDS_PER_COLUMN * ((columns == 8'd0) ? 256 : int'(columns));
    endfunction

    // Random seed and reserved bits
    function automatic conf_word_t make_config(input logic enable, input column_count_t columns);
        conf_word_t word;
        word = conf_word_t'({$random(seed), $random(seed)});
        word[ENABLE_BIT] = enable;
        word[COLUMNS_MSB:COLUMNS_LSB] = columns;
        return word;
    endfunction

    task automatic wait_columns(input int count);
        int target;
        target = data_columns + count;
        while (data_columns < target) @(posedge clock_33);
    endtask

    // Mode 0 master with eight clock_33 cycles per spi_clk period
    task automatic spi_transfer(input conf_word_t word, input int nbits,
                                output conf_word_t readback);
        readback = '0;
        spi_ss <= 1'b0;
        repeat (4) @(posedge clock_33);
        for (int i = nbits - 1; i >= 0; i--) begin
            spi_mosi <= word[i];
            repeat (4) @(posedge clock_33);
            spi_clk <= 1'b1;
            readback = {readback[CONF_BITS-2:0], spi_miso};
            repeat (4) @(posedge clock_33);
            spi_clk <= 1'b0;
        end
        repeat (4) @(posedge clock_33);
        spi_ss <= 1'b1;
        repeat (8) @(posedge clock_33);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////////////////////////

    task automatic close_frame();
        lane_word_t expected;
        if (frame_words.size() == CONF_BITS) begin
            for (int i = 0; i < CONF_BITS; i++) begin
                expected = {LANES{sent_config[CONF_BITS-1-i]}};
                assert (frame_words[i] == expected)
                    else report_mismatch(48'(expected), 48'(frame_words[i]));
            end
            active_config = sent_config;
            word_index = 0;
            config_frames++;
        end else if (frame_words.size() == WORDS_PER_COLUMN) begin
            for (int i = 0; i < WORDS_PER_COLUMN; i++) begin
                expected = rotate_left(active_config[SEED_MSB:SEED_LSB], word_index % LANES);
                assert (frame_words[i] == expected)
                    else report_mismatch(48'(expected), 48'(frame_words[i]));
                word_index = (word_index + 1 == revolution_words(active_config)) ? 0
                                                                                : word_index + 1;
            end
            data_columns++;
        end else begin
            $display("Frame of %0d words closed by lat during %s", frame_words.size(), test_name);
            errors++;
        end
        lat_count++;
        frame_words.delete();
    endtask

    always @(posedge clock_33) begin
        sclk_q <= driver_sclk;
        if (driver_sclk && !sclk_q) begin
            frame_words.push_back(driver_sin);
        end
        if (driver_lat) begin
            close_frame();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        conf_word_t readback;
        conf_word_t expected_readback;
        int         frames_before;
        int         gap;
        int         sclk_rises;

        nrst     <= 1'b0;
        spi_clk  <= 1'b0;
        spi_ss   <= 1'b1;
        spi_mosi <= 1'b0;
        repeat (2) @(posedge clock_33);
        nrst <= 1'b1;

        start_test("reset_idle");
        repeat (100) begin
            @(posedge clock_33);
            assert ({driver_sclk, driver_lat, driver_gclk} == 3'b000)
                else report_mismatch(48'd0, 48'({driver_sclk, driver_lat, driver_gclk}));
        end
        assert (lat_count == 0) else report_mismatch(48'd0, 48'(lat_count));
        end_test();

        start_test("config_frame");
        sent_config = make_config(1'b1, 8'd3);
        spi_transfer(sent_config, CONF_BITS, readback);
        while (config_frames == 0) @(posedge clock_33);
        assert (data_columns == 0) else report_mismatch(48'd0, 48'(data_columns));
        end_test();

        // Seven columns cross two revolution wraps
        start_test("column_rotation");
        wait_columns(7);
        end_test();

        start_test("second_seed");
        wait_columns(1);
        frames_before = config_frames;
        sent_config = make_config(1'b1, 8'd3);
        spi_transfer(sent_config, CONF_BITS, readback);
        while (config_frames == frames_before) @(posedge clock_33);
        wait_columns(4);
        end_test();

        // gclk restarts right after the blanking window
        start_test("blanking");
        repeat (3) begin
            while (!driver_lat) @(posedge clock_33);
            @(posedge clock_33);
            gap = 0;
            while (!driver_gclk && gap < 4 * BLANKING_CYCLES) begin
                gap++;
                @(posedge clock_33);
            end
            assert (gap == BLANKING_CYCLES) else report_mismatch(48'(BLANKING_CYCLES), 48'(gap));
        end
        end_test();

        // A stray frame would be taken before the second column ends
        start_test("short_transfer");
        frames_before = config_frames;
        spi_transfer(make_config(1'b1, 8'd5), 40, readback);
        wait_columns(2);
        assert (config_frames == frames_before)
            else report_mismatch(48'(frames_before), 48'(config_frames));
        end_test();

        start_test("readback");
        expected_readback = sent_config;
        frames_before = config_frames;
        sent_config = make_config(1'b0, 8'd3);
        spi_transfer(sent_config, CONF_BITS, readback);
        assert (readback == expected_readback) else report_mismatch(expected_readback, readback);
        end_test();

        start_test("disable");
        while (config_frames == frames_before) @(posedge clock_33);
        sclk_rises = 0;
        repeat (200) begin
            @(posedge clock_33);
            if (driver_sclk && !sclk_q) begin
                sclk_rises++;
            end
        end
        assert (sclk_rises == 0) else report_mismatch(48'd0, 48'(sclk_rises));
        end_test();

        $display("Tests run %0d, check failures %0d, assertion failures %0d", tests_run, errors,
                 total_failures() - errors);
        if (total_failures() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pov_driver_top.f ====
rtl/pov_driver_pkg.sv
rtl/spi_config_receiver.sv
rtl/column_pattern_source.sv
rtl/driver_shift_engine.sv
rtl/pov_driver_top.sv
bench/pov_driver_assertions.sv
bench/pov_driver_tb.sv

// ==== rtl/column_pattern_source.sv ====
`default_nettype none

module column_pattern_source (
    input  wire                             clock_33,
    input  wire                             nrst,
    input  wire                             config_applied,
    input  wire pov_driver_pkg::conf_word_t active_config,
    output pov_driver_pkg::lane_word_t      pattern_word,
    output logic                            pattern_valid,
    input  wire                             pattern_ready
);

    import pov_driver_pkg::*;

    lane_word_t    seed;
    column_count_t column_last;
    column_count_t column_cnt;
    logic          enable;
    logic [3:0]    word_cnt;
    logic          reload;
    logic          accept;
    logic          restart;
    logic          column_end;
    logic          revolution_end;
    logic          load_seed;

    //////////////////////////////////////////////////////////////////////
    // Configuration fields
    //////////////////////////////////////////////////////////////////////

    assign seed   = active_config[SEED_MSB:SEED_LSB];
    assign enable = active_config[ENABLE_BIT];

    // A zero count wraps to 255 here, i.e. 256 columns
    assign column_last = active_config[COLUMNS_MSB:COLUMNS_LSB] - column_count_t'(1);

    //////////////////////////////////////////////////////////////////////
    // Word and column counters
    //////////////////////////////////////////////////////////////////////

    assign accept         = pattern_valid & pattern_ready;
    assign restart        = config_applied | ~enable;
    assign column_end     = word_cnt == 4'(WORDS_PER_COLUMN - 1);
    assign revolution_end = column_end && column_cnt == column_last;
    assign load_seed      = reload | (accept & revolution_end);

    // Valid drops for at least one cycle on any restart
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            pattern_valid <= 1'b0;
            reload        <= 1'b1;
            word_cnt      <= '0;
            column_cnt    <= '0;
        end else if (restart) begin
            pattern_valid <= 1'b0;
            reload        <= 1'b1;
            word_cnt      <= '0;
            column_cnt    <= '0;
        end else if (reload) begin
            pattern_valid <= 1'b1;
            reload        <= 1'b0;
        end else if (accept) begin
            if (column_end) begin
                word_cnt   <= '0;
                column_cnt <= revolution_end ? '0 : column_cnt + column_count_t'(1);
            end else begin
                word_cnt <= word_cnt + 4'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pattern register
    //////////////////////////////////////////////////////////////////////

    // One left rotation per accepted word gives seed rotated by n mod 30
    always_ff @(posedge clock_33) begin
        if (load_seed) begin
            pattern_word <= seed;
        end else if (accept) begin
            pattern_word <= {pattern_word[LANES-2:0], pattern_word[LANES-1]};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/driver_shift_engine.sv ====
`default_nettype none

module driver_shift_engine (
    input  wire                             clock_33,
    input  wire                             nrst,
    input  wire pov_driver_pkg::conf_word_t config_word,
    input  wire                             new_config,
    output logic                            config_applied,
    output pov_driver_pkg::conf_word_t      active_config,
    input  wire pov_driver_pkg::lane_word_t pattern_word,
    input  wire                             pattern_valid,
    output logic                            pattern_ready,
    output logic                            driver_sclk,
    output logic                            driver_lat,
    output logic                            driver_gclk,
    output pov_driver_pkg::lane_word_t      driver_sin
);

    import pov_driver_pkg::*;

    typedef enum logic [2:0] {
        idle,
        config_shift,
        data_shift,
        latch,
        blank
    } shift_state_t;

    shift_state_t state;
    shift_state_t state_next;
    conf_word_t   pending_word;
    conf_word_t   conf_shift;
    logic         pending;
    logic         take_config;
    logic         shifting;
    logic         shift_phase;
    logic [5:0]   word_cnt;
    logic [5:0]   last_word;
    logic [3:0]   blank_cnt;
    logic         gclk_enable;

    assign take_config   = (state == idle) && pending;
    assign shifting      = (state == config_shift) || (state == data_shift);
    assign last_word     = (state == config_shift) ? 6'(CONF_BITS - 1)
                                                   : 6'(WORDS_PER_COLUMN - 1);
    assign pattern_ready = (state == data_shift) && !shift_phase;
    assign gclk_enable   = take_config ? pending_word[ENABLE_BIT] : active_config[ENABLE_BIT];

    //////////////////////////////////////////////////////////////////////
    // Pending and active configuration
    //////////////////////////////////////////////////////////////////////

    // A newer word simply overwrites one still waiting
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            pending <= 1'b0;
        end else if (new_config) begin
            pending <= 1'b1;
        end else if (take_config) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clock_33) begin
        if (new_config) begin
            pending_word <= config_word;
        end
    end

    // All zeros after reset keeps the display disabled
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            active_config  <= '0;
            config_applied <= 1'b0;
        end else begin
            config_applied <= take_config;
            if (take_config) begin
                active_config <= pending_word;
            end
        end
    end

    always_ff @(posedge clock_33) begin
        if (take_config) begin
            conf_shift <= pending_word;
        end else if (state == config_shift && shift_phase) begin
            conf_shift <= {conf_shift[CONF_BITS-2:0], 1'b0};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Frame sequencing
    //////////////////////////////////////////////////////////////////////

    // Frame boundaries are only ever decided in idle
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (pending) begin
                    state_next = config_shift;
                end else if (active_config[ENABLE_BIT] && pattern_valid) begin
                    state_next = data_shift;
                end
            end
            config_shift, data_shift: begin
                if (shift_phase && word_cnt == last_word) begin
                    state_next = latch;
                end
            end
            latch: begin
                if (shift_phase) begin
                    state_next = blank;
                end
            end
            blank: begin
                if (blank_cnt == 4'(BLANKING_CYCLES)) begin
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

    // Phase 0 sets up sin with sclk low, phase 1 raises sclk
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            state       <= idle;
            shift_phase <= 1'b0;
            word_cnt    <= '0;
            blank_cnt   <= '0;
            driver_sclk <= 1'b0;
            driver_lat  <= 1'b0;
            driver_gclk <= 1'b0;
            driver_sin  <= '0;
        end else begin
            state       <= state_next;
            driver_sclk <= shifting && shift_phase;
            driver_lat  <= (state == latch) && shift_phase;
            // gclk is held low through lat and the whole blanking window
            driver_gclk <= (gclk_enable && state_next != blank) ? ~driver_gclk : 1'b0;
            case (state)
                idle: begin
                    shift_phase <= 1'b0;
                    word_cnt    <= '0;
                    blank_cnt   <= '0;
                end
                config_shift: begin
                    if (!shift_phase) begin
                        driver_sin  <= {LANES{conf_shift[CONF_BITS-1]}};
                        shift_phase <= 1'b1;
                    end else begin
                        shift_phase <= 1'b0;
                        word_cnt    <= word_cnt + 6'd1;
                    end
                end
                data_shift: begin
                    if (!shift_phase) begin
                        if (pattern_valid) begin
                            driver_sin  <= pattern_word;
                            shift_phase <= 1'b1;
                        end
                    end else begin
                        shift_phase <= 1'b0;
                        word_cnt    <= word_cnt + 6'd1;
                    end
                end
                // First cycle returns sclk low, second raises lat
                latch: shift_phase <= ~shift_phase;
                blank: blank_cnt <= blank_cnt + 4'd1;
                default: shift_phase <= 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pov_driver_pkg.sv ====
`default_nettype none

package pov_driver_pkg;

    //////////////////////////////////////////////////////////////////////
    // Frame geometry
    //////////////////////////////////////////////////////////////////////

    // One configuration word, shifted to the drivers as one frame
    localparam int CONF_BITS = 48;

    // Daisy-chained driver lanes, one sin line each
    localparam int LANES = 30;

    // sclk pulses per data column
    localparam int WORDS_PER_COLUMN = 16;

    // Dead time after lat before gclk and sclk resume
    localparam int BLANKING_CYCLES = 8;

    //////////////////////////////////////////////////////////////////////
    // Configuration word fields
    //////////////////////////////////////////////////////////////////////

    localparam int SEED_LSB = 0;
    localparam int SEED_MSB = 29;

    // A count of 0 stands for 256 columns
    localparam int COLUMNS_LSB = 30;
    localparam int COLUMNS_MSB = 37;

    // Bits 38 to 46 reserved but still shifted out
    localparam int ENABLE_BIT = 47;

    typedef logic [CONF_BITS-1:0] conf_word_t;
    typedef logic [LANES-1:0]     lane_word_t;
    typedef logic [7:0]           column_count_t;

endpackage

`default_nettype wire

// ==== rtl/pov_driver_top.sv ====
`default_nettype none

module pov_driver_top (
    input  wire                        clock_33,
    input  wire                        nrst,
    input  wire                        spi_clk,
    input  wire                        spi_ss,
    input  wire                        spi_mosi,
    output logic                       spi_miso,
    output logic                       driver_sclk,
    output logic                       driver_lat,
    output logic                       driver_gclk,
    output pov_driver_pkg::lane_word_t driver_sin
);

    import pov_driver_pkg::*;

    conf_word_t config_word;
    logic       new_config;
    logic       config_applied;
    conf_word_t active_config;
    lane_word_t pattern_word;
    logic       pattern_valid;
    logic       pattern_ready;

    //////////////////////////////////////////////////////////////////////
    // Configuration link
    //////////////////////////////////////////////////////////////////////

    spi_config_receiver spi_config_receiver_inst (
        .clock_33    (clock_33),
        .nrst        (nrst),
        .spi_clk     (spi_clk),
        .spi_ss      (spi_ss),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .config_word (config_word),
        .new_config  (new_config)
    );

    //////////////////////////////////////////////////////////////////////
    // Framebuffer stand-in
    //////////////////////////////////////////////////////////////////////

    column_pattern_source column_pattern_source_inst (
        .clock_33       (clock_33),
        .nrst           (nrst),
        .config_applied (config_applied),
        .active_config  (active_config),
        .pattern_word   (pattern_word),
        .pattern_valid  (pattern_valid),
        .pattern_ready  (pattern_ready)
    );

    //////////////////////////////////////////////////////////////////////
    // LED driver chain
    //////////////////////////////////////////////////////////////////////

    driver_shift_engine driver_shift_engine_inst (
        .clock_33       (clock_33),
        .nrst           (nrst),
        .config_word    (config_word),
        .new_config     (new_config),
        .config_applied (config_applied),
        .active_config  (active_config),
        .pattern_word   (pattern_word),
        .pattern_valid  (pattern_valid),
        .pattern_ready  (pattern_ready),
        .driver_sclk    (driver_sclk),
        .driver_lat     (driver_lat),
        .driver_gclk    (driver_gclk),
        .driver_sin     (driver_sin)
    );

endmodule

`default_nettype wire

// ==== rtl/spi_config_receiver.sv ====
`default_nettype none

module spi_config_receiver (
    input  wire                        clock_33,
    input  wire                        nrst,
    input  wire                        spi_clk,
    input  wire                        spi_ss,
    input  wire                        spi_mosi,
    output logic                       spi_miso,
    output pov_driver_pkg::conf_word_t config_word,
    output logic                       new_config
);

    import pov_driver_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Pin synchronizers and edge detection
    //////////////////////////////////////////////////////////////////////

    // Two flops against metastability, the third one for edges
    logic [2:0] sck_sync;
    logic [2:0] ss_sync;
    logic [1:0] mosi_sync;
    logic       sck_rise;
    logic       sck_fall;
    logic       ss_fall;
    logic       ss_rise;
    logic       selected;

    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            sck_sync  <= '0;
            ss_sync   <= '1;
            mosi_sync <= '0;
        end else begin
            sck_sync  <= {sck_sync[1:0], spi_clk};
            ss_sync   <= {ss_sync[1:0], spi_ss};
            mosi_sync <= {mosi_sync[0], spi_mosi};
        end
    end

    assign sck_rise = sck_sync[1] & ~sck_sync[2];
    assign sck_fall = ~sck_sync[1] & sck_sync[2];
    assign ss_fall  = ~ss_sync[1] & ss_sync[2];
    assign ss_rise  = ss_sync[1] & ~ss_sync[2];
    assign selected = ~ss_sync[1];

    //////////////////////////////////////////////////////////////////////
    // Receive path
    //////////////////////////////////////////////////////////////////////

    conf_word_t rx_shift;
    logic [5:0] bit_cnt;

    // Saturates so an overlong frame never aliases to 48
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            bit_cnt <= '0;
        end else if (ss_fall) begin
            bit_cnt <= '0;
        end else if (selected && sck_rise && bit_cnt != '1) begin
            bit_cnt <= bit_cnt + 6'd1;
        end
    end

    // Mode 0, MSB first, sampled on the rising spi_clk edge
    always_ff @(posedge clock_33) begin
        if (selected && sck_rise) begin
            rx_shift <= {rx_shift[CONF_BITS-2:0], mosi_sync[1]};
        end
    end

    // Commit only complete frames
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            config_word <= '0;
            new_config  <= 1'b0;
        end else begin
            new_config <= 1'b0;
            if (ss_rise && bit_cnt == 6'(CONF_BITS)) begin
                config_word <= rx_shift;
                new_config  <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Readback path
    //////////////////////////////////////////////////////////////////////

    conf_word_t tx_shift;

    // Snapshot at select, advance after each falling spi_clk edge
    always_ff @(posedge clock_33 or negedge nrst) begin
        if (!nrst) begin
            tx_shift <= '0;
        end else if (ss_fall) begin
            tx_shift <= config_word;
        end else if (selected && sck_fall) begin
            tx_shift <= {tx_shift[CONF_BITS-2:0], 1'b0};
        end
    end

    assign spi_miso = tx_shift[CONF_BITS-1];

endmodule

`default_nettype wire
